// ==== bench/ecc_tb.sv ====
module ecc_tb
    import ecc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_encode = 60;
    localparam int n_clean  = 40;
    localparam int n_single = 50;
    localparam int n_double = 40;
    localparam int max_jobs = 200;
    // one job is roughly 15 cycles of apb traffic, 40 leaves slack
    localparam int cycle_limit = max_jobs * 40 + 500;
    localparam int poll_limit  = 20;

    logic      clk;
    logic      rst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    int          n_mismatch  = 0;
    int          n_other     = 0;
    int          n_jobs      = 0;
    int          cycle_count = 0;
    int unsigned seed_ret;

    ecc_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic print_counts();
        $display("summary: %0d jobs, %0d mismatches, %0d other errors",
                 n_jobs, n_mismatch, n_other);
    endtask

    // hard stop if a handshake never completes
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            n_other++;
            $display("timeout: run went past %0d cycles without finishing", cycle_limit);
            print_counts();
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input apb_data_t exp, input apb_data_t got);
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic report_failure(input string msg);
        n_other++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // setup phase on one falling edge, access phase on the next
    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // response is combinational, settled well before the rising edge
        #1;
        err = pslverr;
        check_value("pready", 32'h1, apb_data_t'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic int info_count(input mode_t m);
        case (m)
            mode_h8:  return info_bits_h8;
            mode_h16: return info_bits_h16;
            default:  return info_bits_h32;
        endcase
    endfunction

    // parity count includes the overall bit
    function automatic int parity_count(input mode_t m);
        case (m)
            mode_h8:  return parity_bits_h8;
            mode_h16: return parity_bits_h16;
            default:  return parity_bits_h32;
        endcase
    endfunction

    // hamming position of info bit idx, powers of two belong to check bits
    function automatic int info_position(input int idx);
        int pos;
        int seen;
        pos  = 2;
        seen = -1;
        while (seen < idx) begin
            pos++;
            if ((pos & (pos - 1)) != 0) begin
                seen++;
            end
        end
        return pos;
    endfunction

    // n bits from lo upwards, right aligned
    function automatic apb_data_t bit_slice(input apb_data_t word, input int lo, input int n);
        apb_data_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i] = word[lo + i];
        end
        return r;
    endfunction

    function automatic apb_data_t model_encode(input mode_t m, input apb_data_t info);
        int         n_info;
        int         n_par;
        logic [4:0] chk;
        logic       ovr;
        apb_data_t  code;
        n_info = info_count(m);
        n_par  = parity_count(m);
        chk    = '0;
        ovr    = 1'b0;
        code   = '0;
        // check bit j is the xor of bit j over positions of the set info bits
        for (int i = 0; i < n_info; i++) begin
            if (info[i]) begin
                chk             = chk ^ 5'(info_position(i));
                ovr             = ~ovr;
                code[n_par + i] = 1'b1;
            end
        end
        for (int j = 0; j < n_par - 1; j++) begin
            code[j] = chk[j];
            ovr     = ovr ^ chk[j];
        end
        // overall bit sits just above the check bits
        code[n_par - 1] = ovr;
        return code;
    endfunction

    function automatic apb_data_t ctrl_word(input logic [1:0] mode_bits, input logic op);
        apb_data_t r;
        r                 = '0;
        r[1:0]            = mode_bits;
        r[ctrl_op_bit]    = op;
        r[ctrl_start_bit] = 1'b1;
        return r;
    endfunction

    // finished job, idle, with the given error flags
    function automatic apb_data_t job_status(input logic single_err, input logic double_err);
        apb_data_t r;
        r                  = '0;
        r[stat_done_bit]   = 1'b1;
        r[stat_single_bit] = single_err;
        r[stat_double_bit] = double_err;
        return r;
    endfunction

    function automatic mode_t random_mode();
        return mode_t'(2'($urandom_range(2, 0)));
    endfunction

    task automatic start_job(input logic [1:0] mode_bits, input logic op, input apb_data_t word);
        logic err;
        apb_write(reg_data, word, err);
        check_value("pslverr on data write", '0, apb_data_t'(err));
        apb_write(reg_ctrl, ctrl_word(mode_bits, op), err);
        check_value("pslverr on start", '0, apb_data_t'(err));
    endtask

    // poll status until done, bounded so a stuck job is reported
    task automatic wait_done(output apb_data_t status);
        apb_data_t st;
        int        polls;
        st    = '0;
        polls = 0;
        while (!st[stat_done_bit] && (polls < poll_limit)) begin
            apb_read(reg_status, st);
            polls++;
        end
        if (!st[stat_done_bit]) begin
            report_failure("job never set done in the status register");
        end
        status = st;
    endtask

    task automatic run_job(input mode_t m, input logic op, input apb_data_t word,
                           output apb_data_t result, output apb_data_t status);
        start_job(m, op, word);
        wait_done(status);
        apb_read(reg_result, result);
        n_jobs++;
    endtask

    task automatic decode_check(input mode_t m, input apb_data_t word, input apb_data_t exp_info,
                                input logic exp_single, input logic exp_double);
        apb_data_t res;
        apb_data_t st;
        run_job(m, 1'b1, word, res, st);
        check_value("reg_result", exp_info, res);
        check_value("reg_status", job_status(exp_single, exp_double), st);
    endtask

    task automatic reset_tests();
        apb_data_t rd;
        apb_read(reg_status, rd);
        check_value("reg_status after reset", '0, rd);
        apb_read(reg_result, rd);
        check_value("reg_result after reset", '0, rd);
        apb_read(reg_ctrl, rd);
        check_value("reg_ctrl after reset", '0, rd);
        apb_read(reg_data, rd);
        check_value("reg_data after reset", '0, rd);
    endtask

    task automatic encode_tests();
        mode_t     m;
        apb_data_t info;
        apb_data_t res;
        apb_data_t st;
        int        total;
        repeat (n_encode) begin
            m     = random_mode();
            info  = bit_slice($urandom, 0, info_count(m));
            total = info_count(m) + parity_count(m);
            run_job(m, 1'b0, info, res, st);
            check_value("reg_result", model_encode(m, info), res);
            check_value("codeword pad bits", '0, bit_slice(res, total, 32 - total));
            check_value("codeword parity", '0, apb_data_t'(^res));
            check_value("reg_status", job_status(1'b0, 1'b0), st);
        end
    endtask

    task automatic clean_tests();
        mode_t     m;
        apb_data_t info;
        repeat (n_clean) begin
            m    = random_mode();
            info = bit_slice($urandom, 0, info_count(m));
            decode_check(m, model_encode(m, info), info, 1'b0, 1'b0);
        end
    endtask

    // any bit of the codeword, overall and check bits included
    task automatic single_error_tests();
        mode_t     m;
        apb_data_t info;
        int        b;
        repeat (n_single) begin
            m    = random_mode();
            info = bit_slice($urandom, 0, info_count(m));
            b    = $urandom_range(info_count(m) + parity_count(m) - 1, 0);
            decode_check(m, model_encode(m, info) ^ (32'h1 << b), info, 1'b1, 1'b0);
        end
    endtask

    // two errors are detected only, info field passes as received
    task automatic double_error_tests();
        mode_t     m;
        apb_data_t bad;
        int        total;
        int        b1;
        int        b2;
        repeat (n_double) begin
            m     = random_mode();
            total = info_count(m) + parity_count(m);
            b1    = $urandom_range(total - 1, 0);
            b2    = b1;
            while (b2 == b1) begin
                b2 = $urandom_range(total - 1, 0);
            end
            bad = model_encode(m, bit_slice($urandom, 0, info_count(m)));
            bad = bad ^ (32'h1 << b1) ^ (32'h1 << b2);
            decode_check(m, bad, bit_slice(bad, parity_count(m), info_count(m)), 1'b0, 1'b1);
        end
    endtask

    task automatic error_tests();
        apb_data_t info;
        apb_data_t exp;
        apb_data_t rd;
        logic      err;
        info = bit_slice($urandom, 0, info_bits_h16);
        exp  = model_encode(mode_h16, info);
        start_job(mode_h16, 1'b0, info);
        // job needs four cycles after acceptance, so this lands while busy
        apb_write(reg_ctrl, ctrl_word(mode_h32, 1'b1), err);
        check_value("pslverr on start while busy", 32'h1, apb_data_t'(err));
        wait_done(rd);
        n_jobs++;
        check_value("reg_status after refused start", job_status(1'b0, 1'b0), rd);
        apb_read(reg_result, rd);
        check_value("reg_result after refused start", exp, rd);
        apb_write(reg_ctrl, ctrl_word(2'b11, 1'b0), err);
        check_value("pslverr on mode 3", 32'h1, apb_data_t'(err));
        apb_write(reg_status, 32'hf, err);
        check_value("pslverr on status write", 32'h1, apb_data_t'(err));
        apb_write(reg_result, 32'h5a5a_a5a5, err);
        check_value("pslverr on result write", 32'h1, apb_data_t'(err));
        // nothing refused may have launched or disturbed the last job
        apb_read(reg_status, rd);
        check_value("reg_status after refused writes", job_status(1'b0, 1'b0), rd);
        apb_read(reg_result, rd);
        check_value("reg_result after refused writes", exp, rd);
    endtask

    initial begin
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        seed_ret = $urandom(29837);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_tests();
        encode_tests();
        clean_tests();
        single_error_tests();
        double_error_tests();
        error_tests();

        print_counts();
        if ((n_mismatch == 0) && (n_other == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== design/codec_if.sv ====
interface codec_if
    import ecc_pkg::*;
();

    // job setup, stable from start until the matching valid
    mode_t  mode;
    code_t  data;
    // single cycle launch pulses
    logic   enc_start;
    logic   dec_start;

    // encoder result
    logic   enc_valid;
    code_t  enc_code;

    // decoder result and error class
    logic   dec_valid;
    info_t  dec_info;
    logic   dec_single;
    logic   dec_double;

    modport ctrl (
        output mode, data, enc_start, dec_start,
        input  enc_valid, enc_code, dec_valid, dec_info, dec_single, dec_double
    );

    modport enc (
        input  mode, data, enc_start,
        output enc_valid, enc_code
    );

    modport dec (
        input  mode, data, dec_start,
        output dec_valid, dec_info, dec_single, dec_double
    );

endinterface

// ==== design/ecc_ctrl.sv ====
module ecc_ctrl
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    codec_if.ctrl     bus
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_t;

    state_t    state_q;
    logic [2:0] ctrl_q;
    apb_data_t data_q;
    apb_data_t result_q;
    apb_data_t status;
    logic      done_q;
    logic      single_q;
    logic      double_q;
    logic      enc_start_q;
    logic      dec_start_q;
    mode_t     job_mode_q;
    code_t     job_data_q;
    logic      wr_access;
    logic      start_req;
    logic      start_bad;
    logic      addr_err;
    logic      start_ok;
    logic      job_done;

    // zero wait states
    assign pready = 1'b1;

    assign wr_access = psel && penable && pwrite;
    assign start_req = pwdata[ctrl_start_bit];
    // one job at a time, mode 3 is not a code
    assign start_bad = start_req && ((state_q == st_busy) || (pwdata[1:0] == 2'b11));

    // read only and unmapped addresses refuse writes
    always_comb begin
        case (paddr)
            reg_ctrl: addr_err = start_bad;
            reg_data: addr_err = 1'b0;
            default:  addr_err = 1'b1;
        endcase
    end

    assign pslverr  = wr_access && addr_err;
    assign start_ok = wr_access && (paddr == reg_ctrl) && start_req && !start_bad;
    assign job_done = bus.enc_valid || bus.dec_valid;

    always_comb begin
        status                  = '0;
        status[stat_busy_bit]   = (state_q == st_busy);
        status[stat_done_bit]   = done_q;
        status[stat_single_bit] = single_q;
        status[stat_double_bit] = double_q;
    end

    // start bit is a trigger only and reads back as zero
    always_comb begin
        case (paddr)
            reg_ctrl:   prdata = apb_data_t'(ctrl_q);
            reg_data:   prdata = data_q;
            reg_result: prdata = result_q;
            reg_status: prdata = status;
            default:    prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= st_idle;
            ctrl_q      <= '0;
            data_q      <= '0;
            result_q    <= '0;
            done_q      <= 1'b0;
            single_q    <= 1'b0;
            double_q    <= 1'b0;
            enc_start_q <= 1'b0;
            dec_start_q <= 1'b0;
            job_mode_q  <= mode_h8;
            job_data_q  <= '0;
        end else begin
            // launch pulse lands one cycle after the accepting access
            enc_start_q <= start_ok && !pwdata[ctrl_op_bit];
            dec_start_q <= start_ok && pwdata[ctrl_op_bit];
            if (wr_access && !addr_err) begin
                case (paddr)
                    reg_ctrl: ctrl_q <= pwdata[2:0];
                    reg_data: data_q <= pwdata;
                    default:  ctrl_q <= ctrl_q;
                endcase
            end
            // freeze the job so later register writes cannot disturb it
            if (start_ok) begin
                state_q    <= st_busy;
                done_q     <= 1'b0;
                single_q   <= 1'b0;
                double_q   <= 1'b0;
                job_mode_q <= mode_t'(pwdata[1:0]);
                job_data_q <= code_t'(data_q);
            end
            if ((state_q == st_busy) && job_done) begin
                state_q <= st_idle;
                done_q  <= 1'b1;
                if (bus.enc_valid) begin
                    result_q <= apb_data_t'(bus.enc_code);
                end else begin
                    result_q <= apb_data_t'(bus.dec_info);
                    single_q <= bus.dec_single;
                    double_q <= bus.dec_double;
                end
            end
        end
    end

    assign bus.mode      = job_mode_q;
    assign bus.data      = job_data_q;
    assign bus.enc_start = enc_start_q;
    assign bus.dec_start = dec_start_q;

    a_one_start: assert property (
        @(posedge clk) disable iff (rst)
        !(bus.enc_start && bus.dec_start)
    ) else $error("encode and decode launched together");

endmodule

// ==== design/ecc_pkg.sv ====
package ecc_pkg;

    // widest mode sets the datapath widths
    localparam int info_width  = 26;
    localparam int code_width  = 32;
    localparam int check_width = 5;
    // check matrix is check_width rows of info_width columns
    // row j sits at bits [j*info_width +: info_width]
    localparam int mat_width   = check_width * info_width;

    typedef enum logic [1:0] {
        mode_h8  = 2'd0,
        mode_h16 = 2'd1,
        mode_h32 = 2'd2
    } mode_t;

    typedef logic [info_width-1:0]  info_t;
    typedef logic [code_width-1:0]  code_t;
    typedef logic [check_width-1:0] check_t;
    typedef logic [3:0]             apb_addr_t;
    typedef logic [31:0]            apb_data_t;

    // per mode sizes, parity count includes the overall bit
    localparam int info_bits_h8    = 4;
    localparam int info_bits_h16   = 11;
    localparam int info_bits_h32   = 26;
    localparam int parity_bits_h8  = 4;
    localparam int parity_bits_h16 = 5;
    localparam int parity_bits_h32 = 6;

    // info bit i sits at the i-th hamming position that is not a power of two
    // check bit j covers it when bit j of that position is set
    function automatic logic [mat_width-1:0] build_check_mat(input int n_info);
        logic [mat_width-1:0] mat;
        int                   col;
        mat = '0;
        col = 0;
        for (int pos = 3; pos < 2 ** check_width; pos++) begin
            if (((pos & (pos - 1)) != 0) && (col < n_info)) begin
                for (int j = 0; j < check_width; j++) begin
                    mat[j * info_width + col] = 1'((pos >> j) & 1);
                end
                col++;
            end
        end
        return mat;
    endfunction

    // rows and columns beyond a small mode stay zero
    localparam logic [mat_width-1:0] check_mat_h8  = build_check_mat(info_bits_h8);
    localparam logic [mat_width-1:0] check_mat_h16 = build_check_mat(info_bits_h16);
    localparam logic [mat_width-1:0] check_mat_h32 = build_check_mat(info_bits_h32);

    function automatic logic [mat_width-1:0] check_mat(input mode_t m);
        case (m)
            mode_h8:  return check_mat_h8;
            mode_h16: return check_mat_h16;
            mode_h32: return check_mat_h32;
            default:  return '0;
        endcase
    endfunction

    function automatic info_t info_mask(input mode_t m);
        case (m)
            mode_h8:  return info_t'({info_bits_h8{1'b1}});
            mode_h16: return info_t'({info_bits_h16{1'b1}});
            mode_h32: return info_t'({info_bits_h32{1'b1}});
            default:  return '0;
        endcase
    endfunction

    // register map
    localparam apb_addr_t reg_ctrl   = 4'h0;
    localparam apb_addr_t reg_data   = 4'h4;
    localparam apb_addr_t reg_result = 4'h8;
    localparam apb_addr_t reg_status = 4'hc;

    // ctrl fields, mode sits in bits 1:0
    localparam int ctrl_op_bit    = 2;
    localparam int ctrl_start_bit = 3;

    // status fields
    localparam int stat_busy_bit   = 0;
    localparam int stat_done_bit   = 1;
    localparam int stat_single_bit = 2;
    localparam int stat_double_bit = 3;

endpackage

// ==== design/ecc_top.sv ====
module ecc_top
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // apb3 slave
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr
);

    // job bus between control and the codec stages
    codec_if i_bus ();

    ecc_ctrl i_ctrl (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .bus     (i_bus)
    );

    hamming_encoder i_enc (
        .clk (clk),
        .rst (rst),
        .bus (i_bus)
    );

    hamming_decoder i_dec (
        .clk (clk),
        .rst (rst),
        .bus (i_bus)
    );

endmodule

// ==== design/gf2_mat_mult.sv ====
module gf2_mat_mult
    import ecc_pkg::*;
#(
    parameter int rows = check_width,
    parameter int cols = info_width
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [rows*cols-1:0]   mat,
    input  info_t                  vec,
    output check_t                 prod
);

    // each output bit is the parity of one matrix row masked by the vector
    always_ff @(posedge clk) begin
        if (rst) begin
            prod <= '0;
        end else begin
            for (int r = 0; r < rows; r++) begin
                prod[r] <= ^(mat[r * cols +: cols] & vec[cols-1:0]);
            end
        end
    end

    // the matrix selection must never feed an undefined mode into the product
    a_prod_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(prod)
    ) else $error("gf2 product has unknown bits");

endmodule

// ==== design/hamming_decoder.sv ====
module hamming_decoder
    import ecc_pkg::*;
(
    input logic clk,
    input logic rst,
    codec_if.dec bus
);

    logic [mat_width-1:0] mat_sel;
    info_t                recv_info;
    info_t                recv_info_q;
    info_t                fixed_info;
    check_t               recv_check;
    check_t               recv_check_q;
    check_t               calc_check;
    check_t               syndrome;
    check_t               col;
    logic                 recv_par;
    logic                 par_q;
    logic                 stage1_valid_q;

    assign mat_sel = check_mat(bus.mode);

    // stage one
    // split the received word by mode, pad bits are left out of the parity
    always_comb begin
        recv_info  = '0;
        recv_check = '0;
        recv_par   = 1'b0;
        case (bus.mode)
            mode_h8: begin
                recv_info  = info_t'(bus.data[parity_bits_h8 +: info_bits_h8]);
                recv_check = check_t'(bus.data[parity_bits_h8-2:0]);
                recv_par   = ^bus.data[info_bits_h8+parity_bits_h8-1:0];
            end
            mode_h16: begin
                recv_info  = info_t'(bus.data[parity_bits_h16 +: info_bits_h16]);
                recv_check = check_t'(bus.data[parity_bits_h16-2:0]);
                recv_par   = ^bus.data[info_bits_h16+parity_bits_h16-1:0];
            end
            mode_h32: begin
                recv_info  = info_t'(bus.data[parity_bits_h32 +: info_bits_h32]);
                recv_check = check_t'(bus.data[parity_bits_h32-2:0]);
                recv_par   = ^bus.data[info_bits_h32+parity_bits_h32-1:0];
            end
            default: begin
                recv_par = 1'b0;
            end
        endcase
    end

    // recompute check bits from the received info
    gf2_mat_mult #(
        .rows (check_width),
        .cols (info_width)
    ) i_check (
        .clk  (clk),
        .rst  (rst),
        .mat  (mat_sel),
        .vec  (recv_info),
        .prod (calc_check)
    );

    always_ff @(posedge clk) begin
        recv_info_q  <= recv_info;
        recv_check_q <= recv_check;
        par_q        <= recv_par;
        if (rst) begin
            stage1_valid_q <= 1'b0;
        end else begin
            stage1_valid_q <= bus.dec_start;
        end
    end

    // stage two
    // syndrome equals the hamming position of a single flipped bit
    assign syndrome = calc_check ^ recv_check_q;

    // matrix column i holds the position of info bit i
    // zero or power of two syndromes never match, so a hit parity bit leaves info alone
    always_comb begin
        fixed_info = recv_info_q;
        col        = '0;
        for (int i = 0; i < info_width; i++) begin
            for (int j = 0; j < check_width; j++) begin
                col[j] = mat_sel[j * info_width + i];
            end
            if (par_q && (col != '0) && (col == syndrome)) begin
                fixed_info[i] = ~fixed_info[i];
            end
        end
    end

    // odd parity means one error, even parity with a syndrome means two
    always_ff @(posedge clk) begin
        bus.dec_info <= fixed_info;
        if (rst) begin
            bus.dec_valid  <= 1'b0;
            bus.dec_single <= 1'b0;
            bus.dec_double <= 1'b0;
        end else begin
            bus.dec_valid  <= stage1_valid_q;
            bus.dec_single <= stage1_valid_q && par_q;
            bus.dec_double <= stage1_valid_q && !par_q && (syndrome != '0);
        end
    end

    a_err_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(bus.dec_single && bus.dec_double)
    ) else $error("decoder reports single and double error together");

endmodule

// ==== design/hamming_encoder.sv ====
module hamming_encoder
    import ecc_pkg::*;
(
    input logic clk,
    input logic rst,
    codec_if.enc bus
);

    logic [mat_width-1:0] mat_sel;
    info_t                info_in;
    info_t                info_q;
    check_t               check_q;
    logic                 stage1_valid_q;
    logic                 overall;
    code_t                code_d;

    // stage one
    // matrix picked by the job mode
    assign mat_sel = check_mat(bus.mode);

    // unused info bits of small modes are forced to zero
    assign info_in = bus.data[info_width-1:0] & info_mask(bus.mode);

    // check bits come out registered, aligned with info_q
    gf2_mat_mult #(
        .rows (check_width),
        .cols (info_width)
    ) i_check (
        .clk  (clk),
        .rst  (rst),
        .mat  (mat_sel),
        .vec  (info_in),
        .prod (check_q)
    );

    always_ff @(posedge clk) begin
        info_q <= info_in;
        if (rst) begin
            stage1_valid_q <= 1'b0;
        end else begin
            stage1_valid_q <= bus.enc_start;
        end
    end

    // stage two
    // overall bit makes the whole codeword even
    // masked info and zero check rows keep the unused bits out
    assign overall = (^info_q) ^ (^check_q);

    // pad, info, overall bit, then check bits with check bit 0 at bit 0
    always_comb begin
        code_d = '0;
        case (bus.mode)
            mode_h8: begin
                code_d[info_bits_h8+parity_bits_h8-1:0] =
                    {info_q[info_bits_h8-1:0], overall, check_q[parity_bits_h8-2:0]};
            end
            mode_h16: begin
                code_d[info_bits_h16+parity_bits_h16-1:0] =
                    {info_q[info_bits_h16-1:0], overall, check_q[parity_bits_h16-2:0]};
            end
            mode_h32: begin
                code_d[info_bits_h32+parity_bits_h32-1:0] =
                    {info_q[info_bits_h32-1:0], overall, check_q[parity_bits_h32-2:0]};
            end
            default: begin
                code_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        bus.enc_code <= code_d;
        if (rst) begin
            bus.enc_valid <= 1'b0;
        end else begin
            bus.enc_valid <= stage1_valid_q;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module ecc_tb -f sources.f

./obj_dir/Vecc_tb 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation finished clean"

// ==== sources.f ====
design/ecc_pkg.sv
design/codec_if.sv
design/gf2_mat_mult.sv
design/hamming_encoder.sv
design/hamming_decoder.sv
design/ecc_ctrl.sv
design/ecc_top.sv
bench/ecc_tb.sv
